// ==== Makefile ====
# Verilator build and run for the receive adapter regression
# The log is searched for the testbench result

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, replay the trace, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --top-module tb_adapt_rx -f flist.f
	./obj_dir/Vtb_adapt_rx > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== adapt_fifo.sv ====
// Single-clock FIFO with wrap-bit pointers
// Exports empty, full and both wrap bits; read data is registered
`timescale 1ns/1ps

module adapt_fifo
  import adapt_pkg::*;
#(
  parameter int DEPTH = 8 // Entries, power of two
) (
  input  logic         s_clk,   // Core clock
  input  logic         s_rst_n, // Sync reset, active low
  input  logic         wr_en,   // Write strobe
  input  data_t        wr_data, // Word to store
  input  logic         rd_en,   // Read strobe
  output fifo_rd_t     rd_out,  // Valid and data, one cycle after read
  output fifo_status_t status   // Flags and wrap bits
);

  localparam int ADDR_W = $clog2(DEPTH); // Address bits into storage
  localparam int PTR_W  = ADDR_W + 1;    // Extra bit marks each wrap

  // Storage
  data_t mem [DEPTH]; // Register array, no reset

  // Pointers
  logic [PTR_W-1:0]  wr_ptr;  // Next slot to write
  logic [PTR_W-1:0]  rd_ptr;  // Next slot to read
  logic [ADDR_W-1:0] wr_addr; // Low bits of write pointer
  logic [ADDR_W-1:0] rd_addr; // Low bits of read pointer
  logic              wr_wrap; // Write pointer wrap bit
  logic              rd_wrap; // Read pointer wrap bit

  // Flags and accepted strobes
  logic fifo_empty; // Nothing stored
  logic fifo_full;  // All slots used
  logic wr_ok;      // Write taken this cycle
  logic rd_ok;      // Read taken this cycle

  // Read port registers
  logic  rd_valid_q; // Pulses after each legal read
  data_t rd_data_q;  // Last word read

  assign wr_addr = wr_ptr[ADDR_W-1:0];
  assign rd_addr = rd_ptr[ADDR_W-1:0];
  assign wr_wrap = wr_ptr[ADDR_W];
  assign rd_wrap = rd_ptr[ADDR_W];

  // Flags follow the registered pointers, so they move the cycle after a strobe
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_addr == rd_addr) && (wr_wrap != rd_wrap);

  // Each strobe judged on its own flag
  assign wr_ok = wr_en && !fifo_full;  // Write into full FIFO is dropped
  assign rd_ok = rd_en && !fifo_empty; // Read from empty FIFO is ignored

  // Write pointer
  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      wr_ptr <= '0;
    end else if (wr_ok) begin
      wr_ptr <= wr_ptr + 1'b1; // Carry into MSB toggles wrap bit
    end
  end

  // Read pointer
  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      rd_ptr <= '0;
    end else if (rd_ok) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage write
  always_ff @(posedge s_clk) begin
    if (wr_ok) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read valid, one-cycle pulse
  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_ok;
    end
  end

  // Read data, held between reads
  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      rd_data_q <= '0; // Known value before first read
    end else if (rd_ok) begin
      rd_data_q <= mem[rd_addr];
    end
  end

  // Outputs
  assign rd_out.valid  = rd_valid_q;
  assign rd_out.data   = rd_data_q;
  assign status.empty  = fifo_empty;
  assign status.full   = fifo_full;
  assign status.wr_msb = wr_wrap; // Toggles once per write wrap
  assign status.rd_msb = rd_wrap; // Toggles once per read wrap

endmodule

// ==== adapt_pkg.sv ====
// Receive adapter shared definitions
// Widths, FIFO depths and the structs passed between FIFOs and top
package adapt_pkg;

  // Sizing
  localparam int DATA_W      = 16; // Data word width
  localparam int MAIN_DEPTH  = 8;  // Main FIFO entries
  localparam int PS_DEPTH    = 4;  // Power-save FIFO entries
  localparam int SYNC_STAGES = 2;  // Flops per bit synchronizer

  // Plain vector types
  typedef logic [DATA_W-1:0] data_t;       // One data word
  typedef logic [1:0]        power_mode_t; // Bit 1 picks main FIFO, bit 0 unused

  // FIFO state seen by latency block and top
  typedef struct packed {
    logic empty;  // Pointers equal
    logic full;   // Same address, wrap bits differ
    logic wr_msb; // Write pointer wrap bit
    logic rd_msb; // Read pointer wrap bit
  } fifo_status_t;

  // Registered read port
  typedef struct packed {
    logic  valid; // One cycle after a legal read
    data_t data;  // Holds last word when valid low
  } fifo_rd_t;

endpackage

// ==== adapt_rx_top.sv ====
// Receive adapter top
// Steers strobes to main or power-save FIFO and muxes their outputs
`timescale 1ns/1ps

module adapt_rx_top
  import adapt_pkg::*;
(
  input  logic        s_clk,           // Core clock
  input  logic        s_rst_n,         // Sync reset, active low
  input  power_mode_t fifo_power_mode, // Bit 1 picks main FIFO, bit 0 ignored
  input  logic        wr_en,           // Write strobe
  input  data_t       wr_data,         // Word to store
  input  logic        rd_en,           // Read strobe
  output fifo_rd_t    rd_out,          // Read port of selected FIFO
  output logic        empty,           // Selected FIFO empty
  output logic        full,            // Selected FIFO full, writes now lost
  output logic        latency_pulse    // Wrap-ahead marker
);

  logic         sel_main;    // Main FIFO in use
  logic         main_wr_en;  // Write strobe to main FIFO
  logic         main_rd_en;  // Read strobe to main FIFO
  logic         ps_wr_en;    // Write strobe to power-save FIFO
  logic         ps_rd_en;    // Read strobe to power-save FIFO
  fifo_rd_t     main_rd_out; // Main FIFO read port
  fifo_rd_t     ps_rd_out;   // Power-save FIFO read port
  fifo_status_t main_status; // Main FIFO flags and wrap bits
  fifo_status_t ps_status;   // Power-save FIFO flags and wrap bits

  assign sel_main = fifo_power_mode[1];

  // Unselected FIFO sees no strobes and keeps its contents
  assign main_wr_en = wr_en && sel_main;
  assign main_rd_en = rd_en && sel_main;
  assign ps_wr_en   = wr_en && !sel_main;
  assign ps_rd_en   = rd_en && !sel_main;

  adapt_fifo #(
    .DEPTH (MAIN_DEPTH)
  ) main_fifo (
    .s_clk   (s_clk),
    .s_rst_n (s_rst_n),
    .wr_en   (main_wr_en),
    .wr_data (wr_data),
    .rd_en   (main_rd_en),
    .rd_out  (main_rd_out),
    .status  (main_status)
  );

  adapt_fifo #(
    .DEPTH (PS_DEPTH)
  ) ps_fifo (
    .s_clk   (s_clk),
    .s_rst_n (s_rst_n),
    .wr_en   (ps_wr_en),
    .wr_data (wr_data),
    .rd_en   (ps_rd_en),
    .rd_out  (ps_rd_out),
    .status  (ps_status)
  );

  latency_measure latency_measure_inst (
    .s_clk           (s_clk),
    .s_rst_n         (s_rst_n),
    .fifo_power_mode (fifo_power_mode),
    .main_status     (main_status),
    .ps_status       (ps_status),
    .latency_pulse   (latency_pulse)
  );

  // Output mux, follows the mode directly
  assign rd_out = sel_main ? main_rd_out : ps_rd_out;
  assign empty  = sel_main ? main_status.empty : ps_status.empty;
  assign full   = sel_main ? main_status.full : ps_status.full;

endmodule

// ==== adapt_trace.txt ====
# One line per clock cycle after reset: mode wr_en rnd wr_data rd_en, then expected
# valid data data_chk empty full latency_pulse; rnd=1 takes data from the LFSR
# Idle after reset, main FIFO selected
2 0 0 0000 0  0 0000 1 1 0 0
# Fill main FIFO with 8 words, ninth write dropped
2 1 0 a001 0  0 0000 1 1 0 0
2 1 0 a002 0  0 0000 1 0 0 0
2 1 0 a003 0  0 0000 1 0 0 0
2 1 0 a004 0  0 0000 1 0 0 0
2 1 0 a005 0  0 0000 1 0 0 0
2 1 0 a006 0  0 0000 1 0 0 0
2 1 0 a007 0  0 0000 1 0 0 0
2 1 0 a008 0  0 0000 1 0 0 0
2 1 0 a009 0  0 0000 1 0 1 0
# Drain in order, pulse rises 3 cycles after the write wrap
2 0 0 0000 1  0 0000 1 0 1 0
2 0 0 0000 1  1 a001 1 0 0 0
2 0 0 0000 1  1 a002 1 0 0 1
2 0 0 0000 1  1 a003 1 0 0 1
2 0 0 0000 1  1 a004 1 0 0 1
2 0 0 0000 1  1 a005 1 0 0 1
2 0 0 0000 1  1 a006 1 0 0 1
2 0 0 0000 1  1 a007 1 0 0 1
# Reads past empty give no valid, data holds
2 0 0 0000 1  1 a008 1 1 0 1
2 0 0 0000 1  0 a008 1 1 0 1
2 0 0 0000 0  0 a008 1 1 0 1
# Read wrap drops the pulse; three writes, one with a read in the same cycle
2 1 0 b001 0  0 a008 1 1 0 0
2 1 0 b002 1  0 a008 1 0 0 0
2 1 0 b003 0  1 b001 1 0 0 0
2 0 0 0000 0  0 b001 1 0 0 0
# Power-save FIFO with mode bit 0 set, LFSR data, fifth write dropped
1 0 0 0000 0  0 0000 1 1 0 0
1 1 1 0000 0  0 0000 1 1 0 0
1 1 1 0000 0  0 0000 1 0 0 0
1 1 1 0000 0  0 0000 1 0 0 0
1 1 1 0000 0  0 0000 1 0 0 0
1 1 1 0000 0  0 0000 1 0 1 0
1 0 0 0000 0  0 0000 1 0 1 0
1 0 0 0000 0  0 0000 1 0 1 0
1 0 0 0000 0  0 0000 1 0 1 1
# Pulse follows the selected FIFO one cycle after each mode change
3 0 0 0000 0  0 b001 1 0 0 1
0 0 0 0000 0  0 0000 1 0 1 0
# Drain power-save FIFO, last read past empty
0 0 0 0000 1  0 0000 1 0 1 1
0 0 0 0000 1  1 0000 0 0 0 1
0 0 0 0000 1  1 0000 0 0 0 1
0 0 0 0000 1  1 0000 0 0 0 1
0 0 0 0000 1  1 0000 0 1 0 1
0 0 0 0000 0  0 0000 0 1 0 1
0 0 0 0000 0  0 0000 0 1 0 1
# Back to main FIFO, earlier words still stored
2 0 0 0000 0  0 b001 1 0 0 0
2 0 0 0000 1  0 b001 1 0 0 0
2 0 0 0000 1  1 b002 1 0 0 0
2 0 0 0000 1  1 b003 1 1 0 0
2 0 0 0000 0  0 b003 1 1 0 0

// ==== bitsync.sv ====
// Multi-flop bit synchronizer
// Each bit is treated independently, chain loads RESET_VAL on reset
`timescale 1ns/1ps

module bitsync
  import adapt_pkg::*;
#(
  parameter int               WIDTH     = 1,  // Bits synchronized side by side
  parameter logic [WIDTH-1:0] RESET_VAL = '0  // Value of every stage after reset
) (
  input  logic             s_clk,    // Destination clock
  input  logic             s_rst_n,  // Sync reset, active low
  input  logic [WIDTH-1:0] data_in,  // Quasi-static source bits
  output logic [WIDTH-1:0] data_out  // Synchronized copy
);

  logic [WIDTH-1:0] sync_q [SYNC_STAGES]; // Stage 0 samples the input

  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= RESET_VAL;
      end
    end else begin
      sync_q[0] <= data_in; // First capture, may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1]; // Settle through the chain
      end
    end
  end

  assign data_out = sync_q[SYNC_STAGES-1]; // Last stage only

endmodule

// ==== flist.f ====
adapt_pkg.sv
bitsync.sv
adapt_fifo.sv
latency_measure.sv
adapt_rx_top.sv
tb_adapt_rx.sv

// ==== latency_measure.sv ====
// Latency marker for the receive FIFOs
// Syncs wrap bits of both FIFOs, pulse is high while write is one wrap ahead
`timescale 1ns/1ps

module latency_measure
  import adapt_pkg::*;
(
  input  logic         s_clk,           // Core clock
  input  logic         s_rst_n,         // Sync reset, active low
  input  power_mode_t  fifo_power_mode, // Bit 1 picks main FIFO
  input  fifo_status_t main_status,     // Main FIFO flags and wrap bits
  input  fifo_status_t ps_status,       // Power-save FIFO flags and wrap bits
  output logic         latency_pulse    // Write wrapped once more than read
);

  logic [1:0] main_msb_sync; // {wr, rd} wrap bits, main FIFO
  logic [1:0] ps_msb_sync;   // {wr, rd} wrap bits, power-save FIFO
  logic       main_diff;     // Main FIFO wrap mismatch
  logic       ps_diff;       // Power-save FIFO wrap mismatch

  // Pointers may come from other domains in the full product
  bitsync #(
    .WIDTH     (2),
    .RESET_VAL (2'b00)
  ) main_msb_bitsync (
    .s_clk    (s_clk),
    .s_rst_n  (s_rst_n),
    .data_in  ({main_status.wr_msb, main_status.rd_msb}),
    .data_out (main_msb_sync)
  );

  bitsync #(
    .WIDTH     (2),
    .RESET_VAL (2'b00)
  ) ps_msb_bitsync (
    .s_clk    (s_clk),
    .s_rst_n  (s_rst_n),
    .data_in  ({ps_status.wr_msb, ps_status.rd_msb}),
    .data_out (ps_msb_sync)
  );

  assign main_diff = main_msb_sync[1] ^ main_msb_sync[0];
  assign ps_diff   = ps_msb_sync[1] ^ ps_msb_sync[0];

  // Third cycle of delay after the two sync stages
  always_ff @(posedge s_clk) begin
    if (!s_rst_n) begin
      latency_pulse <= 1'b0;
    end else begin
      latency_pulse <= fifo_power_mode[1] ? main_diff : ps_diff; // Mode change seen next cycle
    end
  end

endmodule

// ==== tb_adapt_rx.sv ====
// Receive adapter testbench
// Replays the cycle trace, checks outputs and cross-checks read data with a queue model
`timescale 1ns/1ps

module tb_adapt_rx
  import adapt_pkg::*;
();

  localparam int    CLK_PERIOD   = 4;                 // ns
  localparam int    RESET_CYCLES = 10;
  localparam int    TRACE_FIELDS = 11;                // Columns per trace line
  localparam string TRACE_FILE   = "adapt_trace.txt";

  // One trace step, stimulus then expected outputs
  typedef struct packed {
    power_mode_t mode;
    logic        wr_en;
    logic        rnd;        // Write data from the LFSR
    data_t       wr_data;
    logic        rd_en;
    fifo_rd_t    exp_rd;
    logic        data_known; // Trace holds the exact read data
    logic        exp_empty;
    logic        exp_full;
    logic        exp_pulse;
  } trace_line_t;

  // DUT ports
  logic        s_clk = 1'b0;
  logic        s_rst_n;
  power_mode_t fifo_power_mode;
  logic        wr_en;
  data_t       wr_data;
  logic        rd_en;
  fifo_rd_t    rd_out;
  logic        empty;
  logic        full;
  logic        latency_pulse;

  trace_line_t trace_q [$];      // Whole trace, loaded at time 0
  bit          trace_loaded = 1'b0;
  logic [31:0] lfsr_state = 32'd73781;

  // Reference queue model, one queue per FIFO
  data_t main_q [$];
  data_t ps_q [$];
  logic  model_valid = 1'b0;     // Read accepted last step
  data_t model_word  = '0;       // Word that read returned

  adapt_rx_top adapt_rx_top_inst (
    .s_clk           (s_clk),
    .s_rst_n         (s_rst_n),
    .fifo_power_mode (fifo_power_mode),
    .wr_en           (wr_en),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_out          (rd_out),
    .empty           (empty),
    .full            (full),
    .latency_pulse   (latency_pulse)
  );

  always #(CLK_PERIOD/2) s_clk = ~s_clk;

  task automatic fail_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  task automatic draw_word(output data_t word);
    for (int b = 0; b < DATA_W; b++) begin
      word[b] = lfsr_state[0]; // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%0b actual=%0b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_rd(string name, fifo_rd_t exp, fifo_rd_t act, logic data_known);
    check_flag({name, ".valid"}, exp.valid, act.valid);
    if (data_known) begin
      check_data({name, ".data"}, exp.data, act.data); // Also covers data held while idle
    end
  endtask

  function automatic bit is_skip_line(string s);
    if (s.len() == 0) begin
      return 1'b1;
    end
    return (s.getc(0) == "#") || (s.getc(0) == "\n") || (s.getc(0) == "\r");
  endfunction

  task automatic load_trace();
    int          fd;
    int          code;
    int          line_no;
    string       line;
    logic [31:0] f_mode, f_wr, f_rnd, f_wdata, f_rd, f_valid;
    logic [31:0] f_data, f_dchk, f_empty, f_full, f_pulse;
    trace_line_t entry;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the trace file %s", TRACE_FILE);
      fail_run();
    end
    line_no = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      if (code != 0 && !is_skip_line(line)) begin
        code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_mode, f_wr, f_rnd, f_wdata,
                       f_rd, f_valid, f_data, f_dchk, f_empty, f_full, f_pulse);
        if (code != TRACE_FIELDS) begin
          $display("Trace file line %0d is malformed, found %0d of %0d fields",
                   line_no, code, TRACE_FIELDS);
          fail_run();
        end
        entry.mode         = f_mode[1:0];
        entry.wr_en        = f_wr[0];
        entry.rnd          = f_rnd[0];
        entry.wr_data      = f_wdata[DATA_W-1:0];
        entry.rd_en        = f_rd[0];
        entry.exp_rd.valid = f_valid[0];
        entry.exp_rd.data  = f_data[DATA_W-1:0];
        entry.data_known   = f_dchk[0];
        entry.exp_empty    = f_empty[0];
        entry.exp_full     = f_full[0];
        entry.exp_pulse    = f_pulse[0];
        trace_q.push_back(entry);
      end
    end
    $fclose(fd);
  endtask

  // Legality judged on occupancy at the start of the cycle
  task automatic model_step(power_mode_t mode, logic we, data_t wd, logic re);
    bit rd_legal;
    bit wr_legal;
    if (mode[1]) begin
      rd_legal = main_q.size() > 0;
      wr_legal = main_q.size() < MAIN_DEPTH;
      if (re && rd_legal) begin
        model_word = main_q.pop_front();
      end
      if (we && wr_legal) begin
        main_q.push_back(wd);
      end
    end else begin
      rd_legal = ps_q.size() > 0;
      wr_legal = ps_q.size() < PS_DEPTH;
      if (re && rd_legal) begin
        model_word = ps_q.pop_front();
      end
      if (we && wr_legal) begin
        ps_q.push_back(wd);
      end
    end
    model_valid = re && rd_legal; // Valid shows up next step
  endtask

  task automatic run_step(int idx);
    trace_line_t t;
    data_t       word;
    string       tag;
    t    = trace_q[idx];
    word = t.wr_data;
    tag  = $sformatf("step%0d", idx);
    @(posedge s_clk);
    if (t.wr_en && t.rnd) begin
      draw_word(word); // Dropped writes still use up LFSR bits
    end
    fifo_power_mode <= t.mode;
    wr_en           <= t.wr_en;
    wr_data         <= word;
    rd_en           <= t.rd_en;
    @(negedge s_clk); // Outputs settled, strobes not yet taken
    check_rd({tag, ".rd_out"}, t.exp_rd, rd_out, t.data_known);
    check_flag({tag, ".empty"}, t.exp_empty, empty);
    check_flag({tag, ".full"}, t.exp_full, full);
    check_flag({tag, ".latency_pulse"}, t.exp_pulse, latency_pulse);
    if (model_valid !== t.exp_rd.valid) begin
      $display("Trace step %0d expects valid %0b but the queue model gives %0b",
               idx, t.exp_rd.valid, model_valid);
      fail_run();
    end
    if (model_valid) begin
      check_data({tag, ".rd_out.data_model"}, model_word, rd_out.data);
    end
    model_step(t.mode, t.wr_en, word, t.rd_en);
  endtask

  // Watchdog, sized from the trace length
  initial begin
    int limit_ns;
    wait (trace_loaded);
    limit_ns = (trace_q.size() + 20) * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout, the trace did not finish within %0d ns", limit_ns);
    fail_run();
  end

  initial begin
    s_rst_n         = 1'b0;
    fifo_power_mode = 2'b10; // Main FIFO
    wr_en           = 1'b0;
    wr_data         = '0;
    rd_en           = 1'b0;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge s_clk);
    s_rst_n <= 1'b1;
    for (int i = 0; i < trace_q.size(); i++) begin
      run_step(i);
    end
    $display("Regression passed");
    $finish;
  end

endmodule
